// ==== common/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  // immediate forms reuse the register-form code and raise use_imm
  typedef enum logic [4:0] {
    OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
    OP_SB, OP_SH, OP_SW,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_JAL, OP_JALR, OP_AUIPC, OP_LUI,
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    OP_INVALID
  } op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word seen through every base format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_word_u;

  // major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== fetch/inst_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
  input  logic [31:0]    inst,
  output fetch_pkg::op_e op,
  output logic [4:0]     rd,
  output logic [4:0]     rs1,
  output logic [4:0]     rs2,
  output logic [31:0]    imm,
  output logic           use_imm,
  output logic           is_branch,
  output logic           is_ls,
  output logic           is_jalr
);

  import fetch_pkg::*;

  inst_word_u  w;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] imm_sh;

  assign w = inst;

  // sign-extended immediate per format
  assign imm_i  = {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
  assign imm_s  = {{20{w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
  assign imm_b  = {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11, w.b.imm_10_5,
                   w.b.imm_4_1, 1'b0};
  assign imm_u  = {w.u.imm_31_12, 12'h000};
  assign imm_j  = {{11{w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12, w.j.imm_11,
                   w.j.imm_10_1, 1'b0};
  assign imm_sh = {27'd0, w.r.rs2}; // shamt of slli/srli/srai

  always_comb begin
    op        = OP_INVALID;
    rd        = w.r.rd;
    rs1       = w.r.rs1;
    rs2       = w.r.rs2;
    imm       = 32'd0;
    use_imm   = 1'b0;
    is_branch = 1'b0;
    is_ls     = 1'b0;
    is_jalr   = 1'b0;

    case (w.r.opcode)
      OPC_LUI: begin
        op      = OP_LUI;
        imm     = imm_u;
        use_imm = 1'b1;
      end
      OPC_AUIPC: begin
        op      = OP_AUIPC;
        imm     = imm_u;
        use_imm = 1'b1;
      end
      OPC_JAL: begin
        op  = OP_JAL;
        imm = imm_j;
      end
      OPC_JALR: begin
        if (w.i.funct3 == 3'd0) op = OP_JALR;
        imm     = imm_i;
        use_imm = 1'b1;
        is_jalr = 1'b1;
      end
      OPC_BRANCH: begin
        case (w.b.funct3)
          3'd0: op = OP_BEQ;
          3'd1: op = OP_BNE;
          3'd4: op = OP_BLT;
          3'd5: op = OP_BGE;
          3'd6: op = OP_BLTU;
          3'd7: op = OP_BGEU;
          default: op = OP_INVALID;
        endcase
        imm       = imm_b;
        is_branch = 1'b1;
      end
      OPC_LOAD: begin
        case (w.i.funct3)
          3'd0: op = OP_LB;
          3'd1: op = OP_LH;
          3'd2: op = OP_LW;
          3'd4: op = OP_LBU;
          3'd5: op = OP_LHU;
          default: op = OP_INVALID;
        endcase
        imm     = imm_i;
        use_imm = 1'b1;
        is_ls   = 1'b1;
      end
      OPC_STORE: begin
        case (w.s.funct3)
          3'd0: op = OP_SB;
          3'd1: op = OP_SH;
          3'd2: op = OP_SW;
          default: op = OP_INVALID;
        endcase
        imm   = imm_s;
        is_ls = 1'b1;
      end
      OPC_OPIMM: begin
        use_imm = 1'b1;
        imm     = imm_i;
        case (w.i.funct3)
          3'd0: op = OP_ADD;
          3'd2: op = OP_SLT;
          3'd3: op = OP_SLTU;
          3'd4: op = OP_XOR;
          3'd6: op = OP_OR;
          3'd7: op = OP_AND;
          3'd1: begin
            if (w.r.funct7 == 7'h00) op = OP_SLL;
            imm = imm_sh;
          end
          default: begin // funct3 5 picks logical or arithmetic by funct7
            if (w.r.funct7 == 7'h00) op = OP_SRL;
            else if (w.r.funct7 == 7'h20) op = OP_SRA;
            imm = imm_sh;
          end
        endcase
      end
      OPC_OP: begin
        if (w.r.funct7 == 7'h00) begin
          case (w.r.funct3)
            3'd0: op = OP_ADD;
            3'd1: op = OP_SLL;
            3'd2: op = OP_SLT;
            3'd3: op = OP_SLTU;
            3'd4: op = OP_XOR;
            3'd5: op = OP_SRL;
            3'd6: op = OP_OR;
            default: op = OP_AND;
          endcase
        end else if (w.r.funct7 == 7'h20) begin
          if (w.r.funct3 == 3'd0) op = OP_SUB;
          else if (w.r.funct3 == 3'd5) op = OP_SRA;
        end
      end
      default: op = OP_INVALID;
    endcase

    // unknown word clears every field and flag
    if (op == OP_INVALID) begin
      rd        = 5'd0;
      rs1       = 5'd0;
      rs2       = 5'd0;
      imm       = 32'd0;
      use_imm   = 1'b0;
      is_branch = 1'b0;
      is_ls     = 1'b0;
      is_jalr   = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== fetch/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic             clk_in,
  input  logic             rst_in,
  output logic [31:0]      fetch_addr,
  input  logic             inst_available,
  input  fetch_pkg::op_e   op,
  input  logic [31:0]      imm,
  input  logic             is_jalr,
  input  logic             queue_full,
  input  logic             jalr_done,
  input  logic [31:0]      jalr_addr,
  input  logic             predict_fail,
  input  logic [31:0]      fail_addr,
  output logic             push,
  output logic [31:0]      push_pc
);

  import fetch_pkg::*;

  logic [31:0] pc;
  logic        jalr_stall; // waiting for the back end to resolve a jalr
  logic [31:0] next_seq_pc;

  assign fetch_addr = pc;
  assign push_pc    = pc;

  // a redirect in this cycle wins over the word sitting at pc
  assign push = inst_available && !jalr_stall && !queue_full
                && !predict_fail && !jalr_done;

  // jal target is known here, so follow it without a bubble
  assign next_seq_pc = (op == OP_JAL) ? pc + imm : pc + 32'd4;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc         <= RESET_PC;
      jalr_stall <= 1'b0;
    end else if (predict_fail) begin
      pc         <= fail_addr;
      jalr_stall <= 1'b0;
    end else if (jalr_done) begin
      pc         <= jalr_addr;
      jalr_stall <= 1'b0;
    end else if (push) begin
      pc <= next_seq_pc;
      if (is_jalr) begin
        jalr_stall <= 1'b1; // target comes later from the alu
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/inst_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_cache #(
  parameter int CACHE_LINES = 16
) (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic [31:0] fetch_addr,
  output logic [31:0] inst,
  output logic        inst_available,
  output logic [31:0] m_axi_araddr,
  output logic [2:0]  m_axi_arprot,
  output logic        m_axi_arvalid,
  input  logic        m_axi_arready,
  input  logic [31:0] m_axi_rdata,
  input  logic [1:0]  m_axi_rresp,
  input  logic        m_axi_rvalid,
  output logic        m_axi_rready
);

  import fetch_pkg::*;

  localparam int IDX_W = $clog2(CACHE_LINES);
  localparam int TAG_W = 30 - IDX_W;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_ADDR = 2'd1;
  localparam logic [1:0] S_DATA = 2'd2;

  logic [31:0]            data_mem [CACHE_LINES];
  logic [TAG_W-1:0]       tag_mem  [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid_q;

  logic [1:0]       state;
  logic [31:0]      miss_addr; // word being refilled stays latched across redirects
  logic [IDX_W-1:0] fetch_idx;
  logic [TAG_W-1:0] fetch_tag;
  logic [IDX_W-1:0] miss_idx;
  logic             hit;
  logic             r_fire;

  assign fetch_idx = fetch_addr[IDX_W+1:2];
  assign fetch_tag = fetch_addr[31:IDX_W+2];
  assign miss_idx  = miss_addr[IDX_W+1:2];

  assign hit            = valid_q[fetch_idx] && (tag_mem[fetch_idx] == fetch_tag);
  assign inst           = data_mem[fetch_idx];
  assign inst_available = hit;

  assign m_axi_araddr  = miss_addr;
  assign m_axi_arprot  = 3'b100; // instruction, secure, unprivileged
  assign m_axi_arvalid = (state == S_ADDR);
  assign m_axi_rready  = (state == S_DATA);
  assign r_fire        = m_axi_rvalid && m_axi_rready;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state   <= S_IDLE;
      valid_q <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (!hit) state <= S_ADDR;
        end
        S_ADDR: begin
          if (m_axi_arready) state <= S_DATA;
        end
        S_DATA: begin
          if (r_fire) begin
            // a bad response leaves the line empty, so idle misses again
            valid_q[miss_idx] <= (m_axi_rresp == AXI_RESP_OKAY);
            state             <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // line payload and the latched miss address
  always_ff @(posedge clk_in) begin
    if (state == S_IDLE && !hit) begin
      miss_addr <= {fetch_addr[31:2], 2'b00};
    end
    if (r_fire) begin
      data_mem[miss_idx] <= m_axi_rdata;
      tag_mem[miss_idx]  <= miss_addr[31:IDX_W+2];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fetch_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic           clk_in,
  input  logic           rst_in,
  input  logic           push,
  input  logic           flush,
  input  logic [31:0]    in_pc,
  input  fetch_pkg::op_e in_op,
  input  logic [4:0]     in_rd,
  input  logic [4:0]     in_rs1,
  input  logic [4:0]     in_rs2,
  input  logic [31:0]    in_imm,
  input  logic           in_use_imm,
  input  logic           in_is_branch,
  input  logic           in_is_ls,
  input  logic           in_is_jalr,
  output logic           queue_full,
  output logic           deq_valid,
  input  logic           deq_ready,
  output logic [31:0]    deq_pc,
  output fetch_pkg::op_e deq_op,
  output logic [4:0]     deq_rd,
  output logic [4:0]     deq_rs1,
  output logic [4:0]     deq_rs2,
  output logic [31:0]    deq_imm,
  output logic           deq_use_imm,
  output logic           deq_is_branch,
  output logic           deq_is_ls,
  output logic           deq_is_jalr
);

  import fetch_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  logic [31:0] pc_mem   [QUEUE_DEPTH];
  op_e         op_mem   [QUEUE_DEPTH];
  logic [14:0] regs_mem [QUEUE_DEPTH]; // rd, rs1, rs2
  logic [31:0] imm_mem  [QUEUE_DEPTH];
  logic [3:0]  flag_mem [QUEUE_DEPTH]; // use_imm, branch, ls, jalr

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign queue_full = (count == QUEUE_DEPTH);
  assign deq_valid  = (count != 0);
  assign do_push    = push && !queue_full;
  assign do_pop     = deq_valid && deq_ready;

  assign deq_pc  = pc_mem[rd_ptr];
  assign deq_op  = op_mem[rd_ptr];
  assign deq_imm = imm_mem[rd_ptr];
  assign {deq_rd, deq_rs1, deq_rs2} = regs_mem[rd_ptr];
  assign {deq_use_imm, deq_is_branch, deq_is_ls, deq_is_jalr} = flag_mem[rd_ptr];

  always_ff @(posedge clk_in) begin
    if (rst_in || flush) begin // mispredict drops everything queued
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (do_push ? 1'b1 : 1'b0) - (do_pop ? 1'b1 : 1'b0);
    end
  end

  always_ff @(posedge clk_in) begin
    if (do_push) begin
      pc_mem[wr_ptr]   <= in_pc;
      op_mem[wr_ptr]   <= in_op;
      regs_mem[wr_ptr] <= {in_rd, in_rs1, in_rs2};
      imm_mem[wr_ptr]  <= in_imm;
      flag_mem[wr_ptr] <= {in_use_imm, in_is_branch, in_is_ls, in_is_jalr};
    end
  end

endmodule

`default_nettype wire

// ==== hdl/frontend_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module frontend_top #(
  parameter logic [31:0] RESET_PC    = 32'h0000_0000,
  parameter int          CACHE_LINES = 16,
  parameter int          QUEUE_DEPTH = 4
) (
  input  logic           clk_in,
  input  logic           rst_in,
  output logic [31:0]    m_axi_araddr,
  output logic [2:0]     m_axi_arprot,
  output logic           m_axi_arvalid,
  input  logic           m_axi_arready,
  input  logic [31:0]    m_axi_rdata,
  input  logic [1:0]     m_axi_rresp,
  input  logic           m_axi_rvalid,
  output logic           m_axi_rready,
  input  logic           jalr_done,
  input  logic [31:0]    jalr_addr,
  input  logic           predict_fail,
  input  logic [31:0]    fail_addr,
  output logic           deq_valid,
  input  logic           deq_ready,
  output logic [31:0]    deq_pc,
  output fetch_pkg::op_e deq_op,
  output logic [4:0]     deq_rd,
  output logic [4:0]     deq_rs1,
  output logic [4:0]     deq_rs2,
  output logic [31:0]    deq_imm,
  output logic           deq_use_imm,
  output logic           deq_is_branch,
  output logic           deq_is_ls,
  output logic           deq_is_jalr
);

  import fetch_pkg::*;

  logic [31:0] fetch_addr;
  logic [31:0] inst;
  logic        inst_available;
  logic        queue_full;
  logic        push;
  logic [31:0] push_pc;

  // decoded fields of the word at fetch_addr
  op_e         dec_op;
  logic [4:0]  dec_rd;
  logic [4:0]  dec_rs1;
  logic [4:0]  dec_rs2;
  logic [31:0] dec_imm;
  logic        dec_use_imm;
  logic        dec_is_branch;
  logic        dec_is_ls;
  logic        dec_is_jalr;

  inst_cache #(.CACHE_LINES(CACHE_LINES)) i_inst_cache (
    .clk_in, .rst_in, .fetch_addr, .inst, .inst_available,
    .m_axi_araddr, .m_axi_arprot, .m_axi_arvalid, .m_axi_arready,
    .m_axi_rdata, .m_axi_rresp, .m_axi_rvalid, .m_axi_rready
  );

  inst_decoder i_inst_decoder (
    .inst, .op(dec_op), .rd(dec_rd), .rs1(dec_rs1), .rs2(dec_rs2),
    .imm(dec_imm), .use_imm(dec_use_imm), .is_branch(dec_is_branch),
    .is_ls(dec_is_ls), .is_jalr(dec_is_jalr)
  );

  fetch_unit #(.RESET_PC(RESET_PC)) i_fetch_unit (
    .clk_in, .rst_in, .fetch_addr, .inst_available,
    .op(dec_op), .imm(dec_imm), .is_jalr(dec_is_jalr), .queue_full,
    .jalr_done, .jalr_addr, .predict_fail, .fail_addr, .push, .push_pc
  );

  fetch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_fetch_queue (
    .clk_in, .rst_in, .push,
    .flush(predict_fail), // mispredict empties the queue
    .in_pc(push_pc), .in_op(dec_op), .in_rd(dec_rd), .in_rs1(dec_rs1),
    .in_rs2(dec_rs2), .in_imm(dec_imm), .in_use_imm(dec_use_imm),
    .in_is_branch(dec_is_branch), .in_is_ls(dec_is_ls), .in_is_jalr(dec_is_jalr),
    .queue_full, .deq_valid, .deq_ready, .deq_pc, .deq_op, .deq_rd,
    .deq_rs1, .deq_rs2, .deq_imm, .deq_use_imm, .deq_is_branch,
    .deq_is_ls, .deq_is_jalr
  );

endmodule

`default_nettype wire

// ==== tests/frontend_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module frontend_chk (
  input logic        clk_in,
  input logic        rst_in,
  input logic        arvalid,
  input logic        arready,
  input logic [31:0] araddr,
  input logic        push,
  input logic        queue_full,
  input logic        flush,
  input logic        deq_valid,
  input logic        deq_ready,
  input logic [31:0] deq_pc,
  input logic [31:0] deq_imm,
  input logic [4:0]  deq_op
);

  int fail_count = 0; // failed assertions so far

  // read address held until the slave accepts it
  ar_stable: assert property (@(posedge clk_in) disable iff (rst_in)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      fail_count++;
      $error("arvalid dropped or araddr changed before arready");
    end

  no_push_full: assert property (@(posedge clk_in) disable iff (rst_in)
    !(push && queue_full))
    else begin
      fail_count++;
      $error("push while the queue is full");
    end

  head_stable: assert property (@(posedge clk_in) disable iff (rst_in)
    deq_valid && !deq_ready && !flush |=> $stable({deq_pc, deq_imm, deq_op}))
    else begin
      fail_count++;
      $error("queue head changed while waiting for deq_ready");
    end

endmodule

`default_nettype wire

// ==== tests/frontend_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module frontend_tb;

  import fetch_pkg::*;

  localparam int WAIT_LIMIT = 200; // cycles allowed for one entry to appear
  localparam int ACT_NONE   = 0;
  localparam int ACT_HOLD   = 1; // back-pressure before taking the entry
  localparam int ACT_JALR   = 2;
  localparam int ACT_FAIL   = 3;
  localparam int ACT_MARK   = 4; // end of first loop pass
  localparam int ACT_REHIT  = 5; // end of second loop pass

  logic        clk_in;
  logic        rst_in = 1'b1;
  logic [31:0] m_axi_araddr;
  logic [2:0]  m_axi_arprot;
  logic        m_axi_arvalid;
  logic        m_axi_arready = 1'b0;
  logic [31:0] m_axi_rdata = 32'd0;
  logic [1:0]  m_axi_rresp = AXI_RESP_OKAY;
  logic        m_axi_rvalid = 1'b0;
  logic        m_axi_rready;
  logic        jalr_done = 1'b0;
  logic [31:0] jalr_addr = 32'd0;
  logic        predict_fail = 1'b0;
  logic [31:0] fail_addr = 32'd0;
  logic        deq_valid;
  logic        deq_ready = 1'b0;
  logic [31:0] deq_pc;
  op_e         deq_op;
  logic [4:0]  deq_rd, deq_rs1, deq_rs2;
  logic [31:0] deq_imm;
  logic        deq_use_imm, deq_is_branch, deq_is_ls, deq_is_jalr;

  // memory model state
  logic [31:0] mem [64];
  logic        rd_pend = 1'b0;
  logic [31:0] rd_addr = 32'd0;
  logic [1:0]  rd_wait = 2'd0;
  int          ar_count = 0;
  integer      seed = 56958;

  // instruction table
  logic [31:0] row_addr [32];
  logic [31:0] row_word [32];
  op_e         row_op   [32];
  logic [4:0]  row_rd   [32];
  logic [4:0]  row_rs1  [32];
  logic [4:0]  row_rs2  [32];
  logic [31:0] row_imm  [32];
  logic [31:0] row_next [32];
  int          row_act  [32];
  int          n_rows = 0;

  int errors = 0;
  int n_checks = 0;
  int ar_mark = 0;
  int assert_fails;
  bit timed_out = 1'b0;

  frontend_top #(
    .RESET_PC(32'h0000_0000),
    .CACHE_LINES(16),
    .QUEUE_DEPTH(4)
  ) i_frontend_top (.*);

  bind inst_cache frontend_chk cache_chk (
    .clk_in, .rst_in, .arvalid(m_axi_arvalid), .arready(m_axi_arready),
    .araddr(m_axi_araddr), .push(1'b0), .queue_full(1'b0), .flush(1'b0),
    .deq_valid(1'b0), .deq_ready(1'b0), .deq_pc(32'd0), .deq_imm(32'd0), .deq_op(5'd0)
  );

  bind fetch_queue frontend_chk queue_chk (
    .clk_in, .rst_in, .arvalid(1'b0), .arready(1'b0), .araddr(32'd0),
    .push, .queue_full, .flush, .deq_valid, .deq_ready, .deq_pc, .deq_imm, .deq_op
  );

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  // AXI4-Lite read slave with random accept and data delays
  always @(posedge clk_in) begin
    if (rst_in) begin
      m_axi_arready <= 1'b0;
      m_axi_rvalid  <= 1'b0;
      rd_pend       <= 1'b0;
    end else begin
      m_axi_arready <= !rd_pend && (($random(seed) & 3) != 0);
      if (m_axi_arvalid && m_axi_arready) begin
        check_value("arprot instruction bit", m_axi_arprot[2], 1'b1);
        rd_pend  <= 1'b1;
        rd_addr  <= m_axi_araddr;
        rd_wait  <= 2'($random(seed));
        ar_count <= ar_count + 1;
      end
      if (rd_pend && !m_axi_rvalid) begin
        if (rd_wait == 2'd0) begin
          m_axi_rvalid <= 1'b1;
          m_axi_rdata  <= mem[rd_addr[7:2]];
          m_axi_rresp  <= AXI_RESP_OKAY;
        end else begin
          rd_wait <= rd_wait - 2'd1;
        end
      end
      if (m_axi_rvalid && m_axi_rready) begin
        m_axi_rvalid <= 1'b0;
        rd_pend      <= 1'b0;
      end
    end
  end

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    inst_word_u w;
    w.r = '{f7, rs2, rs1, f3, rd, OPC_OP};
    return w;
  endfunction

  function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    inst_word_u w;
    w.i = '{imm, rs1, f3, rd, opc};
    return w;
  endfunction

  function automatic logic [31:0] s_word(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [11:0] imm);
    inst_word_u w;
    w.s = '{imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    return w;
  endfunction

  function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    inst_word_u w;
    w.b = '{imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    return w;
  endfunction

  function automatic logic [31:0] u_word(input logic [6:0] opc, input logic [4:0] rd,
                                         input logic [19:0] imm);
    inst_word_u w;
    w.u = '{imm, rd, opc};
    return w;
  endfunction

  function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] imm);
    inst_word_u w;
    w.j = '{imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    return w;
  endfunction

  task automatic add_row(input logic [31:0] a, input logic [31:0] w, input op_e o,
                         input logic [4:0] d, input logic [4:0] s1, input logic [4:0] s2,
                         input logic [31:0] i, input logic [31:0] nx, input int act);
    row_addr[n_rows] = a;
    row_word[n_rows] = w;
    row_op[n_rows]   = o;
    row_rd[n_rows]   = d;
    row_rs1[n_rows]  = s1;
    row_rs2[n_rows]  = s2;
    row_imm[n_rows]  = i;
    row_next[n_rows] = nx;
    row_act[n_rows]  = act;
    mem[a[7:2]]      = w;
    n_rows++;
  endtask

  // five-word loop closed by a backward jal
  task automatic add_loop(input int last_act);
    add_row(32'ha0, i_word(OPC_OPIMM, 3'd7, 5'd9, 5'd9, 12'd7), OP_AND,
            5'd9, 5'd9, 5'd0, 32'd7, 32'ha4, ACT_NONE);
    add_row(32'ha4, i_word(OPC_OPIMM, 3'd1, 5'd10, 5'd9, 12'd3), OP_SLL,
            5'd10, 5'd9, 5'd0, 32'd3, 32'ha8, ACT_NONE);
    add_row(32'ha8, i_word(OPC_OPIMM, 3'd5, 5'd11, 5'd10, 12'h402), OP_SRA,
            5'd11, 5'd10, 5'd0, 32'd2, 32'hac, ACT_NONE);
    add_row(32'hac, r_word(7'h00, 5'd10, 5'd11, 3'd6, 5'd12), OP_OR,
            5'd12, 5'd11, 5'd10, 32'd0, 32'hb0, ACT_NONE);
    add_row(32'hb0, j_word(5'd0, 21'h1ffff0), OP_JAL,
            5'd0, 5'd0, 5'd0, 32'hffff_fff0, 32'ha0, last_act);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic wait_deq_valid(input int k);
    int n;
    n = 0;
    @(negedge clk_in);
    while (!deq_valid && n < WAIT_LIMIT) begin
      @(negedge clk_in);
      n++;
    end
    if (!deq_valid) begin
      timed_out = 1'b1;
      $display("timeout: the queue produced no entry for table row %0d", k);
    end
  endtask

  // only fields that the format carries are compared
  task automatic compare_row(input int k);
    logic [6:0] opc;
    opc = row_word[k][6:0];
    check_value("pc", deq_pc, row_addr[k]);
    if (k > 0) check_value("pc after previous entry", deq_pc, row_next[k-1]);
    check_value("op", deq_op, row_op[k]);
    if (opc != OPC_STORE && opc != OPC_BRANCH) check_value("rd", deq_rd, row_rd[k]);
    if (opc != OPC_LUI && opc != OPC_AUIPC && opc != OPC_JAL) begin
      check_value("rs1", deq_rs1, row_rs1[k]);
    end
    if (opc == OPC_OP || opc == OPC_STORE || opc == OPC_BRANCH) begin
      check_value("rs2", deq_rs2, row_rs2[k]);
    end
    check_value("imm", deq_imm, row_imm[k]);
    if (opc == OPC_OP || opc == OPC_OPIMM || opc == OPC_BRANCH) begin
      check_value("use_imm", deq_use_imm, opc == OPC_OPIMM);
    end
    check_value("is_jalr", deq_is_jalr, row_op[k] == OP_JALR);
    check_value("is_branch", deq_is_branch, opc == OPC_BRANCH);
    check_value("is_ls", deq_is_ls, opc == OPC_LOAD || opc == OPC_STORE);
  endtask

  task automatic pop_entry();
    @(posedge clk_in);
    deq_ready <= 1'b1;
    @(posedge clk_in);
    deq_ready <= 1'b0; // head leaves on this edge
  endtask

  task automatic send_redirect(input bit mispredict, input logic [31:0] target);
    @(posedge clk_in);
    if (mispredict) begin
      predict_fail <= 1'b1;
      fail_addr    <= target;
    end else begin
      jalr_done <= 1'b1;
      jalr_addr <= target;
    end
    @(posedge clk_in);
    predict_fail <= 1'b0;
    jalr_done    <= 1'b0;
  endtask

  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = {i[24:0], 7'h7f}; // undecodable opcode tagged by word index
    end
    add_row(32'h00, i_word(OPC_OPIMM, 3'd0, 5'd1, 5'd0, 12'd5), OP_ADD,
            5'd1, 5'd0, 5'd0, 32'd5, 32'h04, ACT_NONE);
    add_row(32'h04, r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), OP_ADD,
            5'd3, 5'd1, 5'd2, 32'd0, 32'h08, ACT_NONE);
    add_row(32'h08, r_word(7'h20, 5'd1, 5'd3, 3'd0, 5'd7), OP_SUB,
            5'd7, 5'd3, 5'd1, 32'd0, 32'h0c, ACT_NONE);
    add_row(32'h0c, i_word(OPC_LOAD, 3'd2, 5'd4, 5'd1, 12'd8), OP_LW,
            5'd4, 5'd1, 5'd0, 32'd8, 32'h10, ACT_HOLD);
    add_row(32'h10, s_word(3'd2, 5'd2, 5'd4, 12'hffc), OP_SW,
            5'd0, 5'd2, 5'd4, 32'hffff_fffc, 32'h14, ACT_NONE);
    add_row(32'h14, b_word(3'd0, 5'd1, 5'd2, 13'd8), OP_BEQ,
            5'd0, 5'd1, 5'd2, 32'd8, 32'h18, ACT_NONE); // not taken without a predictor
    add_row(32'h18, u_word(OPC_LUI, 5'd5, 20'h12345), OP_LUI,
            5'd5, 5'd0, 5'd0, 32'h1234_5000, 32'h1c, ACT_NONE);
    add_row(32'h1c, u_word(OPC_AUIPC, 5'd6, 20'h00001), OP_AUIPC,
            5'd6, 5'd0, 5'd0, 32'h0000_1000, 32'h20, ACT_NONE);
    add_row(32'h20, j_word(5'd1, 21'd16), OP_JAL,
            5'd1, 5'd0, 5'd0, 32'd16, 32'h30, ACT_NONE);
    add_row(32'h30, i_word(OPC_OPIMM, 3'd4, 5'd8, 5'd3, 12'hfff), OP_XOR,
            5'd8, 5'd3, 5'd0, 32'hffff_ffff, 32'h34, ACT_NONE);
    add_row(32'h34, i_word(OPC_JALR, 3'd0, 5'd0, 5'd1, 12'd0), OP_JALR,
            5'd0, 5'd1, 5'd0, 32'd0, 32'h80, ACT_JALR);
    add_row(32'h80, b_word(3'd1, 5'd2, 5'd3, 13'd32), OP_BNE,
            5'd0, 5'd2, 5'd3, 32'd32, 32'ha0, ACT_FAIL);
    add_loop(ACT_MARK);
    add_loop(ACT_REHIT);

    repeat (16) @(posedge clk_in);
    rst_in <= 1'b0;

    for (int k = 0; k < n_rows; k++) begin
      wait_deq_valid(k);
      if (timed_out) break;
      if (row_act[k] == ACT_HOLD) begin
        repeat (40) begin
          @(negedge clk_in);
          check_value("deq_valid while held", deq_valid, 1'b1);
        end
      end
      compare_row(k);
      pop_entry();
      case (row_act[k])
        ACT_JALR: begin
          repeat (20) begin
            @(negedge clk_in);
            check_value("deq_valid during jalr stall", deq_valid, 1'b0);
          end
          send_redirect(1'b0, row_next[k]);
        end
        ACT_FAIL:  send_redirect(1'b1, row_next[k]);
        ACT_MARK:  ar_mark = ar_count;
        ACT_REHIT: check_value("address reads in second loop pass", ar_count, ar_mark);
        default: ;
      endcase
    end

    assert_fails = i_frontend_top.i_inst_cache.cache_chk.fail_count
                   + i_frontend_top.i_fetch_queue.queue_chk.fail_count;
    $display("%0d checks, %0d mismatches, %0d assertion failures, timeout %0d",
             n_checks, errors, assert_fails, timed_out);
    if (errors == 0 && assert_fails == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
common/fetch_pkg.sv
fetch/inst_decoder.sv
fetch/fetch_unit.sv
hdl/inst_cache.sv
hdl/fetch_queue.sv
hdl/frontend_top.sv
tests/frontend_chk.sv
tests/frontend_tb.sv

// ==== Bender.yml ====
package:
  name: frontend

sources:
  - files:
      - common/fetch_pkg.sv
      - fetch/inst_decoder.sv
      - fetch/fetch_unit.sv
      - hdl/inst_cache.sv
      - hdl/fetch_queue.sv
      - hdl/frontend_top.sv
  - target: test
    files:
      - tests/frontend_chk.sv
      - tests/frontend_tb.sv
